// File: Bender.yml
package:
  name: mips_core

sources:
  - hw/mips_pkg.sv
  - hw/mips_if.sv
  - hw/decode_unit.sv
  - hw/reg_file.sv
  - hw/alu.sv
  - hw/execute_stage.sv
  - hw/mem_stage.sv
  - hw/mips_core.sv
  - target: test
    files:
      - verif/mips_core_props.sv
      - verif/tb_mips_core.sv

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import mips_pkg::*; (
	input  logic [XLEN-1:0]    a,
	input  logic [XLEN-1:0]    b,
	input  logic [ALU_OPW-1:0] op,
	output logic [XLEN-1:0]    result,
	output logic               zero
);

	// shift amount from the low bits of a
	logic [$clog2(XLEN)-1:0] shamt;

	assign shamt = a[$clog2(XLEN)-1:0];

	always_comb
	begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_NOR:  result = ~(a | b);
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
			ALU_SLL:  result = b << shamt;
			ALU_SRL:  result = b >> shamt;
			// arithmetic shift keeps the sign of rt
			ALU_SRA:  result = $unsigned($signed(b) >>> shamt);
			default:  result = '0;
		endcase
	end

	// beq/bne look at this after a subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import mips_pkg::*; (
	input  inst_t inst,
	dec_if.dec    ctrl
);

	always_comb
	begin
		// defaults form a bubble, so unknown encodings fall through here
		ctrl.reg_write  = 1'b0;
		ctrl.reg_dst    = DST_RT;
		ctrl.wb_sel     = WB_ALU;
		ctrl.alu_op     = ALU_ADD;
		ctrl.b_src      = B_SIMM;
		ctrl.shift_sa   = 1'b0;
		ctrl.mem_read   = 1'b0;
		ctrl.mem_write  = 1'b0;
		ctrl.store_byte = 1'b0;
		ctrl.load_kind  = LD_WORD;
		ctrl.branch_eq  = 1'b0;
		ctrl.branch_ne  = 1'b0;
		ctrl.jump       = 1'b0;
		ctrl.jump_link  = 1'b0;
		ctrl.jump_reg   = 1'b0;
		case (inst.i.op)
			OP_SPECIAL:
			begin
				ctrl.reg_dst   = DST_RD;
				ctrl.b_src     = B_RT;
				// constant shifts take sa in place of rs
				ctrl.shift_sa  = inst.r.funct inside {FN_SLL, FN_SRL, FN_SRA};
				ctrl.jump_reg  = inst.r.funct inside {FN_JR, FN_JALR};
				ctrl.jump_link = inst.r.funct == FN_JALR;
				ctrl.wb_sel    = (inst.r.funct == FN_JALR) ? WB_LINK : WB_ALU;
				ctrl.reg_write = inst.r.funct != FN_JR;
				case (inst.r.funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_NOR:  ctrl.alu_op = ALU_NOR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_SLTU: ctrl.alu_op = ALU_SLTU;
					FN_SLL:  ctrl.alu_op = ALU_SLL;
					FN_SRL:  ctrl.alu_op = ALU_SRL;
					FN_SRA:  ctrl.alu_op = ALU_SRA;
					FN_JR, FN_JALR: ctrl.alu_op = ALU_ADD;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI:
			begin
				ctrl.reg_write = 1'b1;
				// logic immediates are zero extended
				ctrl.b_src = (inst.i.op inside {OP_ANDI, OP_ORI, OP_XORI}) ? B_ZIMM : B_SIMM;
				case (inst.i.op)
					OP_SLTI:  ctrl.alu_op = ALU_SLT;
					OP_SLTIU: ctrl.alu_op = ALU_SLTU;
					OP_ANDI:  ctrl.alu_op = ALU_AND;
					OP_ORI:   ctrl.alu_op = ALU_OR;
					OP_XORI:  ctrl.alu_op = ALU_XOR;
					default:  ctrl.alu_op = ALU_ADD;
				endcase
			end
			OP_LUI:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_LUI;
			end
			OP_LW, OP_LB, OP_LBU:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.wb_sel    = WB_LOAD;
				ctrl.load_kind = (inst.i.op == OP_LW) ? LD_WORD :
					(inst.i.op == OP_LB) ? LD_BYTE : LD_UBYTE;
			end
			OP_SW, OP_SB:
			begin
				ctrl.mem_write  = 1'b1;
				ctrl.store_byte = inst.i.op == OP_SB;
			end
			OP_BEQ, OP_BNE:
			begin
				// compare through the alu zero flag
				ctrl.alu_op    = ALU_SUB;
				ctrl.b_src     = B_RT;
				ctrl.branch_eq = inst.i.op == OP_BEQ;
				ctrl.branch_ne = inst.i.op == OP_BNE;
			end
			OP_J, OP_JAL:
			begin
				ctrl.jump      = 1'b1;
				ctrl.jump_link = inst.j.op == OP_JAL;
				ctrl.reg_write = inst.j.op == OP_JAL;
				ctrl.reg_dst   = DST_RA;
				ctrl.wb_sel    = WB_LINK;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	input  inst_t             inst_word,
	dec_if.ex                 ctrl,
	input  logic [XLEN-1:0]   rdata1,
	input  logic [XLEN-1:0]   rdata2,
	output logic [REG_AW-1:0] raddr1,
	output logic [REG_AW-1:0] raddr2,
	wb_if.fwd                 fwd,
	exm_if.ex                 exm,
	output logic [XLEN-1:0]   next_pc,
	output logic              data_sram_en,
	output logic [3:0]        data_sram_wen,
	output logic [XLEN-1:0]   data_sram_addr,
	output logic [XLEN-1:0]   data_sram_wdata
);

	// pc is the address of the word in decode, ex_pc the one in execute
	logic [XLEN-1:0]    pc, ex_pc;
	inst_t              ex_inst;
	logic               ex_valid;
	logic               ex_reg_write, ex_mem_read, ex_mem_write, ex_store_byte, ex_shift_sa;
	logic               ex_branch_eq, ex_branch_ne, ex_jump, ex_jump_link, ex_jump_reg;
	logic [1:0]         ex_reg_dst, ex_wb_sel, ex_b_src, ex_load_kind;
	logic [ALU_OPW-1:0] ex_alu_op;
	logic [XLEN-1:0]    rs_val, rt_val, simm, zimm, alu_a, alu_b, alu_result;
	logic               alu_zero, taken;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			pc       <= RESET_PC;
			ex_valid <= 1'b0;
		end
		else
		begin
			pc       <= next_pc;
			// decode holds a real word every cycle after reset
			ex_valid <= 1'b1;
		end
	end

	// decode to execute, no stalls so loaded every cycle
	always_ff @(posedge clk)
	begin
		ex_pc         <= pc;
		ex_inst       <= inst_word;
		ex_reg_write  <= ctrl.reg_write;
		ex_reg_dst    <= ctrl.reg_dst;
		ex_wb_sel     <= ctrl.wb_sel;
		ex_alu_op     <= ctrl.alu_op;
		ex_b_src      <= ctrl.b_src;
		ex_shift_sa   <= ctrl.shift_sa;
		ex_mem_read   <= ctrl.mem_read;
		ex_mem_write  <= ctrl.mem_write;
		ex_store_byte <= ctrl.store_byte;
		ex_load_kind  <= ctrl.load_kind;
		ex_branch_eq  <= ctrl.branch_eq;
		ex_branch_ne  <= ctrl.branch_ne;
		ex_jump       <= ctrl.jump;
		ex_jump_link  <= ctrl.jump_link;
		ex_jump_reg   <= ctrl.jump_reg;
	end

	// operands read here, write-back value bypassed in
	assign raddr1 = ex_inst.r.rs;
	assign raddr2 = ex_inst.r.rt;
	assign rs_val = (fwd.wen && fwd.waddr == raddr1) ? fwd.wdata : rdata1;
	assign rt_val = (fwd.wen && fwd.waddr == raddr2) ? fwd.wdata : rdata2;

	assign simm  = {{(XLEN-16){ex_inst.i.imm[15]}}, ex_inst.i.imm};
	assign zimm  = {{(XLEN-16){1'b0}}, ex_inst.i.imm};
	assign alu_a = ex_shift_sa ? {{(XLEN-5){1'b0}}, ex_inst.r.sa} : rs_val;
	assign alu_b = (ex_b_src == B_RT) ? rt_val : (ex_b_src == B_SIMM) ? simm : zimm;

	alu i_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (ex_alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	assign taken = ex_valid && ((ex_branch_eq && alu_zero) || (ex_branch_ne && !alu_zero));

	// redirect lands after the delay slot, which sits in decode at pc
	always_comb
	begin
		if (!resetn)
			next_pc = RESET_PC;
		else if (ex_valid && ex_jump_reg)
			next_pc = rs_val;
		else if (ex_valid && ex_jump)
			next_pc = {pc[XLEN-1:XLEN-4], ex_inst.j.target, 2'b00};
		else if (taken)
			next_pc = pc + {simm[XLEN-3:0], 2'b00};
		else
			next_pc = pc + XLEN'(4);
	end

	// data SRAM request goes out from execute
	assign data_sram_en    = ex_valid && (ex_mem_read || ex_mem_write);
	assign data_sram_addr  = alu_result;
	assign data_sram_wen   = !(ex_valid && ex_mem_write) ? 4'b0000 :
		ex_store_byte ? (4'b0001 << alu_result[1:0]) : 4'b1111;
	// sb copies the byte to every lane, the strobe picks one
	assign data_sram_wdata = ex_store_byte ? {4{exm.rt_value[7:0]}} : exm.rt_value;

	assign exm.valid     = ex_valid;
	assign exm.pc        = ex_pc;
	assign exm.inst      = ex_inst;
	assign exm.result    = alu_result;
	assign exm.rt_value  = rt_val;
	assign exm.reg_write = ex_reg_write;
	assign exm.reg_dst   = ex_reg_dst;
	assign exm.wb_sel    = ex_wb_sel;
	assign exm.load_kind = ex_load_kind;
	// return address skips the delay slot
	assign exm.link_pc   = ex_jump_link ? ex_pc + XLEN'(8) : '0;

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mips_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	exm_if.mem                exm,
	input  logic [XLEN-1:0]   data_sram_rdata,
	wb_if.mem                 wb,
	output logic [XLEN-1:0]   debug_wb_pc,
	output logic [3:0]        debug_wb_rf_wen,
	output logic [REG_AW-1:0] debug_wb_rf_wnum,
	output logic [XLEN-1:0]   debug_wb_rf_wdata
);

	logic              mem_valid, mem_reg_write;
	logic [XLEN-1:0]   mem_pc, mem_result, mem_link_pc;
	inst_t             mem_inst;
	logic [1:0]        mem_reg_dst, mem_wb_sel, mem_load_kind;
	logic [7:0]        load_byte;
	logic [XLEN-1:0]   load_value, wdata;
	logic [REG_AW-1:0] waddr;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			mem_valid <= 1'b0;
		else
			mem_valid <= exm.valid;
	end

	always_ff @(posedge clk)
	begin
		mem_pc        <= exm.pc;
		mem_inst      <= exm.inst;
		mem_result    <= exm.result;
		mem_reg_write <= exm.reg_write;
		mem_reg_dst   <= exm.reg_dst;
		mem_wb_sel    <= exm.wb_sel;
		mem_load_kind <= exm.load_kind;
		mem_link_pc   <= exm.link_pc;
	end

	// byte lane from address bits 1:0, read data arrives this cycle
	assign load_byte = data_sram_rdata[{mem_result[1:0], 3'b000} +: 8];

	always_comb
	begin
		case (mem_load_kind)
			LD_BYTE:  load_value = {{(XLEN-8){load_byte[7]}}, load_byte};
			LD_UBYTE: load_value = {{(XLEN-8){1'b0}}, load_byte};
			default:  load_value = data_sram_rdata;
		endcase
		case (mem_reg_dst)
			DST_RT:  waddr = mem_inst.r.rt;
			DST_RD:  waddr = mem_inst.r.rd;
			default: waddr = REG_AW'(31);
		endcase
		case (mem_wb_sel)
			WB_LOAD: wdata = load_value;
			WB_LINK: wdata = mem_link_pc;
			WB_LUI:  wdata = {mem_inst.i.imm, {(XLEN-16){1'b0}}};
			default: wdata = mem_result;
		endcase
	end

	// r0 writes dropped here so forwarding never sees them
	assign wb.wen   = mem_valid && mem_reg_write && (waddr != '0);
	assign wb.waddr = waddr;
	assign wb.wdata = wdata;

	// trace one cycle after the register write
	always_ff @(posedge clk)
	begin
		if (!resetn)
			debug_wb_rf_wen <= 4'b0000;
		else
			debug_wb_rf_wen <= {4{wb.wen}};
	end

	always_ff @(posedge clk)
	begin
		if (wb.wen)
		begin
			debug_wb_pc       <= mem_pc;
			debug_wb_rf_wnum  <= waddr;
			debug_wb_rf_wdata <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: hw/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	output logic              inst_sram_en,
	output logic [3:0]        inst_sram_wen,
	output logic [XLEN-1:0]   inst_sram_addr,
	output logic [XLEN-1:0]   inst_sram_wdata,
	input  logic [XLEN-1:0]   inst_sram_rdata,
	output logic              data_sram_en,
	output logic [3:0]        data_sram_wen,
	output logic [XLEN-1:0]   data_sram_addr,
	output logic [XLEN-1:0]   data_sram_wdata,
	input  logic [XLEN-1:0]   data_sram_rdata,
	output logic [XLEN-1:0]   debug_wb_pc,
	output logic [3:0]        debug_wb_rf_wen,
	output logic [REG_AW-1:0] debug_wb_rf_wnum,
	output logic [XLEN-1:0]   debug_wb_rf_wdata
);

	dec_if dec_bus ();
	exm_if exm_bus ();
	wb_if  wb_bus ();

	logic [REG_AW-1:0] raddr1, raddr2;
	logic [XLEN-1:0]   rdata1, rdata2;

	// fetch port is read-only and always enabled
	assign inst_sram_en    = 1'b1;
	assign inst_sram_wen   = 4'b0000;
	assign inst_sram_wdata = '0;

	// fetched word is decoded straight off the SRAM
	decode_unit i_decode_unit (
		.inst (inst_sram_rdata),
		.ctrl (dec_bus.dec)
	);

	reg_file i_reg_file (
		.clk    (clk),
		.resetn (resetn),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wb     (wb_bus.rf)
	);

	// next_pc doubles as the fetch address
	execute_stage i_execute_stage (
		.clk             (clk),
		.resetn          (resetn),
		.inst_word       (inst_sram_rdata),
		.ctrl            (dec_bus.ex),
		.rdata1          (rdata1),
		.rdata2          (rdata2),
		.raddr1          (raddr1),
		.raddr2          (raddr2),
		.fwd             (wb_bus.fwd),
		.exm             (exm_bus.ex),
		.next_pc         (inst_sram_addr),
		.data_sram_en    (data_sram_en),
		.data_sram_wen   (data_sram_wen),
		.data_sram_addr  (data_sram_addr),
		.data_sram_wdata (data_sram_wdata)
	);

	mem_stage i_mem_stage (
		.clk               (clk),
		.resetn            (resetn),
		.exm               (exm_bus.mem),
		.data_sram_rdata   (data_sram_rdata),
		.wb                (wb_bus.mem),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_wen   (debug_wb_rf_wen),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

endmodule

`default_nettype wire

// File: hw/mips_if.sv
`timescale 1ns/1ps
`default_nettype none

// control fields of the word now in decode
interface dec_if import mips_pkg::*; ();
	logic               reg_write;
	logic [1:0]         reg_dst, wb_sel, b_src, load_kind;
	logic [ALU_OPW-1:0] alu_op;
	logic               shift_sa;
	logic               mem_read, mem_write, store_byte;
	logic               branch_eq, branch_ne;
	logic               jump, jump_link, jump_reg;

	modport dec (output reg_write, reg_dst, wb_sel, alu_op, b_src, shift_sa, mem_read,
		mem_write, store_byte, load_kind, branch_eq, branch_ne, jump, jump_link, jump_reg);
	modport ex (input reg_write, reg_dst, wb_sel, alu_op, b_src, shift_sa, mem_read,
		mem_write, store_byte, load_kind, branch_eq, branch_ne, jump, jump_link, jump_reg);
endinterface

// instruction in execute, sampled by memory/write-back
interface exm_if import mips_pkg::*; ();
	logic            valid;
	logic [XLEN-1:0] pc, result, rt_value, link_pc;
	inst_t           inst;
	logic            reg_write;
	logic [1:0]      reg_dst, wb_sel, load_kind;

	// rt_value only feeds the store lanes on the execute side
	modport ex (output valid, pc, inst, result, rt_value, reg_write, reg_dst, wb_sel,
		load_kind, link_pc);
	modport mem (input valid, pc, inst, result, reg_write, reg_dst, wb_sel, load_kind, link_pc);
endinterface

// register-file write, also the forwarding source
interface wb_if import mips_pkg::*; ();
	logic              wen;
	logic [REG_AW-1:0] waddr;
	logic [XLEN-1:0]   wdata;

	modport mem (output wen, waddr, wdata);
	modport rf (input wen, waddr, wdata);
	modport fwd (input wen, waddr, wdata);
endinterface

`default_nettype wire

// File: hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// word and register-file geometry
	localparam int XLEN    = 32;
	localparam int REG_AW  = 5;
	localparam int ALU_OPW = 4;

	// first fetch after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000;

	// primary opcodes, bits 31:26
	localparam logic [5:0] OP_SPECIAL = 6'h00, OP_J = 6'h02, OP_JAL = 6'h03, OP_BEQ = 6'h04,
		OP_BNE = 6'h05, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI = 6'h0c,
		OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LUI = 6'h0f, OP_LB = 6'h20, OP_LW = 6'h23,
		OP_LBU = 6'h24, OP_SB = 6'h28, OP_SW = 6'h2b;

	// function field of SPECIAL
	localparam logic [5:0] FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_JR = 6'h08,
		FN_JALR = 6'h09, FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25,
		FN_XOR = 6'h26, FN_NOR = 6'h27, FN_SLT = 6'h2a, FN_SLTU = 6'h2b;

	// alu operations
	localparam logic [ALU_OPW-1:0] ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_AND = 4'd2,
		ALU_OR = 4'd3, ALU_XOR = 4'd4, ALU_NOR = 4'd5, ALU_SLT = 4'd6, ALU_SLTU = 4'd7,
		ALU_SLL = 4'd8, ALU_SRL = 4'd9, ALU_SRA = 4'd10;

	// second alu operand
	localparam logic [1:0] B_RT = 2'd0, B_SIMM = 2'd1, B_ZIMM = 2'd2;
	// write-back source
	localparam logic [1:0] WB_ALU = 2'd0, WB_LOAD = 2'd1, WB_LINK = 2'd2, WB_LUI = 2'd3;
	// destination register field
	localparam logic [1:0] DST_RT = 2'd0, DST_RD = 2'd1, DST_RA = 2'd2;
	// load width and extension
	localparam logic [1:0] LD_WORD = 2'd0, LD_BYTE = 2'd1, LD_UBYTE = 2'd2;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0]        op;
			logic [REG_AW-1:0] rs;
			logic [REG_AW-1:0] rt;
			logic [REG_AW-1:0] rd;
			logic [4:0]        sa;
			logic [5:0]        funct;
		} r;
		struct packed {
			logic [5:0]        op;
			logic [REG_AW-1:0] rs;
			logic [REG_AW-1:0] rt;
			logic [15:0]       imm;
		} i;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target;
		} j;
	} inst_t;

endpackage

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import mips_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	input  logic [REG_AW-1:0] raddr1,
	input  logic [REG_AW-1:0] raddr2,
	output logic [XLEN-1:0]   rdata1,
	output logic [XLEN-1:0]   rdata2,
	wb_if.rf                  wb
);

	// no storage behind r0
	logic [XLEN-1:0] regs [1:2**REG_AW-1];

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			for (int k = 1; k < 2**REG_AW; k++)
				regs[k] <= '0;
		end
		// wen never comes with address zero
		else if (wb.wen)
		begin
			regs[wb.waddr] <= wb.wdata;
		end
	end

	// async read, r0 hardwired
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: mips_core.f
hw/mips_pkg.sv
hw/mips_if.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/mips_core.sv
verif/mips_core_props.sv
verif/tb_mips_core.sv

// File: verif/mips_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_props import mips_pkg::*; (
	input logic              clk,
	input logic              resetn,
	input logic [XLEN-1:0]   inst_sram_addr,
	input logic              data_sram_en,
	input logic [3:0]        data_sram_wen,
	input logic [3:0]        debug_wb_rf_wen,
	input logic [REG_AW-1:0] debug_wb_rf_wnum
);

	// stage registers settle after the first reset edge
	quiet_in_reset: assert property (@(posedge clk) (!resetn) [*2] |->
		!data_sram_en && data_sram_wen == 4'b0000 && debug_wb_rf_wen == 4'b0000)
		else $error("memory or trace strobe active during reset");

	// fetch held at the vector
	fetch_at_vector: assert property (@(posedge clk) !resetn |-> inst_sram_addr == RESET_PC)
		else $error("fetch address differs from reset vector");

	// r0 writes never traced
	no_r0_trace: assert property (@(posedge clk) disable iff (!resetn)
		debug_wb_rf_wen != 4'b0000 |-> debug_wb_rf_wnum != '0)
		else $error("trace reports a write to r0");

endmodule

bind mips_core mips_core_props i_mips_core_props (.*);

`default_nettype wire

// File: verif/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ;

	localparam int TRACE_TIMEOUT = 40;
	localparam int RESET_CYCLES  = 10;

	logic              clk;
	logic              resetn;
	logic              inst_sram_en;
	logic [3:0]        inst_sram_wen;
	logic [XLEN-1:0]   inst_sram_addr, inst_sram_wdata, inst_sram_rdata;
	logic              data_sram_en;
	logic [3:0]        data_sram_wen;
	logic [XLEN-1:0]   data_sram_addr, data_sram_wdata, data_sram_rdata;
	logic [XLEN-1:0]   debug_wb_pc, debug_wb_rf_wdata;
	logic [3:0]        debug_wb_rf_wen;
	logic [REG_AW-1:0] debug_wb_rf_wnum;

	// word-indexed memories, 1 KiB window
	logic [XLEN-1:0]   imem [0:255];
	logic [XLEN-1:0]   dmem [0:255];
	logic [XLEN-1:0]   icap, dcap;
	// stores seen on the data port
	logic [3:0]        wen_log [$];
	logic [XLEN-1:0]   addr_log [$];
	// expected trace, in program order
	logic [XLEN-1:0]   exp_pc [$];
	logic [REG_AW-1:0] exp_num [$];
	logic [XLEN-1:0]   exp_data [$];
	int unsigned       slot;
	int                seed;

	mips_core i_mips_core (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// sram capture on the rising edge when enabled, strobed byte writes
	always @(posedge clk)
	begin
		if (inst_sram_en)
			icap <= imem[inst_sram_addr[9:2]];
		if (data_sram_en)
			dcap <= dmem[data_sram_addr[9:2]];
		if (data_sram_en && data_sram_wen != 4'b0000)
		begin
			for (int b = 0; b < 4; b++)
				if (data_sram_wen[b])
					dmem[data_sram_addr[9:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
			wen_log.push_back(data_sram_wen);
			addr_log.push_back(data_sram_addr);
		end
	end

	// read data shows up one cycle after the address, driven mid-cycle
	always @(negedge clk)
	begin
		inst_sram_rdata <= icap;
		data_sram_rdata <= dcap;
	end

	function automatic logic [XLEN-1:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [XLEN-1:0] itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// jump to word index idx of the program
	function automatic logic [XLEN-1:0] jtype(input logic [5:0] op, input int unsigned idx);
		logic [XLEN-1:0] dest;
		dest = RESET_PC + 32'(4 * idx);
		return {op, dest[27:2]};
	endfunction

	// background pattern, unique per byte address
	function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
		return (addr * 32'h0001_0003) ^ 32'h6d2e_91b7;
	endfunction

	task automatic check_word(input string what, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_reg(input string what, input logic [REG_AW-1:0] got,
		input logic [REG_AW-1:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got r%0d, expected r%0d", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "register number mismatch");
		end
	endtask

	// fetch side is read-only and always on
	task automatic check_fetch_port();
		check_word("fetch enable", {31'h0, inst_sram_en}, 32'h1);
		check_word("fetch write strobe", {28'h0, inst_sram_wen}, '0);
		check_word("fetch write data", inst_sram_wdata, '0);
	endtask

	// reset asserted, memories and queues cleared, program starts at slot 0
	task automatic start_test();
		@(negedge clk);
		resetn = 1'b0;
		for (int k = 0; k < 256; k++)
		begin
			imem[k] = '0;
			dmem[k] = fill_word(32'(4 * k));
		end
		wen_log.delete();
		addr_log.delete();
		exp_pc.delete();
		exp_num.delete();
		exp_data.delete();
		slot = 0;
	endtask

	// place one word, rd zero means no trace expected
	task automatic put(input logic [XLEN-1:0] word, input logic [REG_AW-1:0] rd,
		input logic [XLEN-1:0] value);
		imem[slot] = word;
		if (rd != '0)
		begin
			exp_pc.push_back(RESET_PC + 32'(4 * slot));
			exp_num.push_back(rd);
			exp_data.push_back(value);
		end
		slot++;
	endtask

	// fetch pinned to the vector and nothing traced while held
	task automatic hold_reset();
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			check_fetch_port();
			check_word("fetch address in reset", inst_sram_addr, RESET_PC);
			check_word("trace enable in reset", {28'h0, debug_wb_rf_wen}, '0);
			check_word("data enable in reset", {31'h0, data_sram_en}, '0);
		end
		resetn = 1'b1;
	endtask

	task automatic next_write(output logic [XLEN-1:0] pc, output logic [REG_AW-1:0] num,
		output logic [XLEN-1:0] data);
		int waited;
		waited = 0;
		@(negedge clk);
		check_fetch_port();
		while (debug_wb_rf_wen == 4'b0000)
		begin
			waited++;
			if (waited > TRACE_TIMEOUT)
			begin
				$display("no register write traced within %0d cycles", TRACE_TIMEOUT);
				$display("SOME TESTS FAILED");
				$fatal(1, "trace timeout");
			end
			@(negedge clk);
			check_fetch_port();
		end
		pc   = debug_wb_pc;
		num  = debug_wb_rf_wnum;
		data = debug_wb_rf_wdata;
	endtask

	// every expected write in order, anything extra shows up as a mismatch
	task automatic run_trace();
		logic [XLEN-1:0]   pc, data;
		logic [REG_AW-1:0] num;
		while (exp_pc.size() > 0)
		begin
			next_write(pc, num, data);
			check_word("trace pc", pc, exp_pc.pop_front());
			check_reg("trace register", num, exp_num.pop_front());
			check_word("trace data", data, exp_data.pop_front());
		end
	endtask

	task automatic test_reset();
		start_test();
		put(itype(OP_ORI, 0, 1, 16'h1234), 1, 32'h1234);
		hold_reset();
		run_trace();
	endtask

	task automatic test_alu();
		logic [XLEN-1:0] a, b, simm, zimm;
		logic [15:0]     imm;
		logic [4:0]      sa;
		a    = $random(seed);
		b    = $random(seed);
		imm  = $random(seed);
		sa   = $random(seed);
		simm = {{16{imm[15]}}, imm};
		zimm = {16'h0, imm};
		start_test();
		// operands built with lui/ori, ori depends on lui directly
		put(itype(OP_LUI, 0, 1, a[31:16]), 1, {a[31:16], 16'h0});
		put(itype(OP_ORI, 1, 1, a[15:0]), 1, a);
		put(itype(OP_LUI, 0, 2, b[31:16]), 2, {b[31:16], 16'h0});
		put(itype(OP_ORI, 2, 2, b[15:0]), 2, b);
		put(rtype(1, 2, 3, 0, FN_ADDU), 3, a + b);
		put(rtype(1, 2, 4, 0, FN_SUBU), 4, a - b);
		put(rtype(1, 2, 5, 0, FN_AND), 5, a & b);
		put(rtype(1, 2, 6, 0, FN_OR), 6, a | b);
		put(rtype(1, 2, 7, 0, FN_XOR), 7, a ^ b);
		put(rtype(1, 2, 8, 0, FN_NOR), 8, ~(a | b));
		put(rtype(1, 2, 9, 0, FN_SLT), 9, 32'($signed(a) < $signed(b)));
		put(rtype(1, 2, 10, 0, FN_SLTU), 10, 32'(a < b));
		put(rtype(0, 2, 11, sa, FN_SLL), 11, b << sa);
		put(rtype(0, 2, 12, sa, FN_SRL), 12, b >> sa);
		put(rtype(0, 2, 13, sa, FN_SRA), 13, $signed(b) >>> sa);
		put(itype(OP_ADDIU, 1, 14, imm), 14, a + simm);
		put(itype(OP_SLTI, 1, 15, imm), 15, 32'($signed(a) < $signed(simm)));
		put(itype(OP_SLTIU, 1, 16, imm), 16, 32'(a < simm));
		put(itype(OP_ANDI, 1, 17, imm), 17, a & zimm);
		put(itype(OP_ORI, 1, 18, imm), 18, a | zimm);
		put(itype(OP_XORI, 1, 19, imm), 19, a ^ zimm);
		// chain through the two previous results
		put(rtype(14, 19, 20, 0, FN_ADDU), 20, (a + simm) + (a ^ zimm));
		put(rtype(20, 3, 21, 0, FN_SUBU), 21, (a + simm) + (a ^ zimm) - (a + b));
		hold_reset();
		run_trace();
	endtask

	task automatic test_zero_reg();
		start_test();
		put(itype(OP_ORI, 0, 1, 16'h0055), 1, 32'h55);
		// neither write to r0 may reach the trace or the bypass
		put(itype(OP_ADDIU, 1, 0, 16'h0005), 0, '0);
		put(rtype(1, 1, 0, 0, FN_ADDU), 0, '0);
		put(rtype(0, 1, 2, 0, FN_ADDU), 2, 32'h55);
		put(rtype(0, 0, 3, 0, FN_OR), 3, '0);
		hold_reset();
		run_trace();
	endtask

	task automatic test_memory();
		logic [XLEN-1:0] val, upper;
		val   = 32'h8a7b_6c5d;
		upper = fill_word(32'h104);
		upper[15:8] = 8'hf0;
		start_test();
		put(itype(OP_ORI, 0, 1, 16'h0100), 1, 32'h100);
		put(itype(OP_LUI, 0, 2, val[31:16]), 2, {val[31:16], 16'h0});
		put(itype(OP_ORI, 2, 2, val[15:0]), 2, val);
		put(itype(OP_SW, 1, 2, 16'd0), 0, '0);
		put(itype(OP_ORI, 0, 3, 16'h00f0), 3, 32'hf0);
		put(itype(OP_SB, 1, 3, 16'd5), 0, '0);
		put(itype(OP_LW, 1, 4, 16'd0), 4, val);
		// every byte lane, both extensions
		for (int k = 0; k < 4; k++)
		begin
			put(itype(OP_LB, 1, 5'(5 + k), 16'(k)), 5'(5 + k),
				{{24{val[8*k+7]}}, val[8*k +: 8]});
			put(itype(OP_LBU, 1, 5'(9 + k), 16'(k)), 5'(9 + k), {24'h0, val[8*k +: 8]});
		end
		put(itype(OP_LW, 1, 13, 16'd4), 13, upper);
		put(itype(OP_LB, 1, 14, 16'd5), 14, 32'hffff_fff0);
		// load result bypassed straight into the add
		put(rtype(14, 14, 15, 0, FN_ADDU), 15, 32'hffff_ffe0);
		hold_reset();
		run_trace();
		check_word("store count", 32'(wen_log.size()), 32'd2);
		check_word("sw strobe", {28'h0, wen_log[0]}, 32'hf);
		check_word("sw address", addr_log[0], 32'h100);
		check_word("sb strobe", {28'h0, wen_log[1]}, 32'h2);
		check_word("sb address", addr_log[1], 32'h105);
		check_word("stored word", dmem[64], val);
		check_word("stored byte", dmem[65], upper);
	endtask

	task automatic test_control();
		start_test();
		put(itype(OP_ORI, 0, 1, 16'd7), 1, 32'd7);
		put(itype(OP_ORI, 0, 2, 16'd7), 2, 32'd7);
		// taken beq to slot 5
		put(itype(OP_BEQ, 1, 2, 16'd2), 0, '0);
		put(itype(OP_ORI, 0, 3, 16'd1), 3, 32'd1);
		put(itype(OP_ORI, 0, 4, 16'd1), 0, '0);
		// untaken bne falls through
		put(itype(OP_BNE, 1, 2, 16'd3), 0, '0);
		put(itype(OP_ORI, 0, 5, 16'd2), 5, 32'd2);
		put(itype(OP_ORI, 0, 6, 16'd3), 6, 32'd3);
		// taken bne to slot 11
		put(itype(OP_BNE, 1, 0, 16'd2), 0, '0);
		put(itype(OP_ORI, 0, 7, 16'd4), 7, 32'd4);
		put(itype(OP_ORI, 0, 8, 16'd4), 0, '0);
		put(jtype(OP_J, 14), 0, '0);
		put(itype(OP_ORI, 0, 9, 16'd5), 9, 32'd5);
		put(itype(OP_ORI, 0, 10, 16'd5), 0, '0);
		// jal to slot 18, link skips the delay slot
		put(jtype(OP_JAL, 18), 31, RESET_PC + 32'(4 * 16));
		put(itype(OP_ORI, 0, 11, 16'd6), 11, 32'd6);
		put(itype(OP_ORI, 0, 12, 16'd6), 0, '0);
		put(itype(OP_ORI, 0, 13, 16'd6), 0, '0);
		put(itype(OP_LUI, 0, 14, RESET_PC[31:16]), 14, {RESET_PC[31:16], 16'h0});
		put(itype(OP_ORI, 14, 14, 16'h005c), 14, RESET_PC + 32'h5c);
		// jalr through r14 to slot 23
		put(rtype(14, 0, 15, 0, FN_JALR), 15, RESET_PC + 32'(4 * 22));
		put(itype(OP_ORI, 0, 16, 16'd8), 16, 32'd8);
		put(itype(OP_ORI, 0, 17, 16'd8), 0, '0);
		put(itype(OP_ORI, 0, 18, 16'd9), 18, 32'd9);
		hold_reset();
		run_trace();
	endtask

	initial
	begin
		seed            = 86947;
		resetn          = 1'b0;
		inst_sram_rdata = '0;
		data_sram_rdata = '0;
		test_reset();
		test_alu();
		test_zero_reg();
		test_memory();
		test_control();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
